/* Makefile */
# Verilator build and run of the lsu forwarding testbench

LOG = sim.log

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator, run, and check the log for the pass message"
	@echo "  clean  remove the build directory and the log"

obj_dir/Vlsu_fwd_tb: vlog.f hw/*.sv tb/*.sv
	verilator --binary --timing --assert -j 0 --top-module lsu_fwd_tb -f vlog.f

test: obj_dir/Vlsu_fwd_tb
	./obj_dir/Vlsu_fwd_tb > $(LOG) 2>&1; true
	@cat $(LOG)
	@grep -q "Simulation finished: PASS" $(LOG)

clean:
	rm -rf obj_dir $(LOG)

/* hw/lsu_bus_master.sv */
// lsu bus master: Wishbone classic beats for dc5 stores and dc2 loads, load response register
`timescale 1ns/1ps

module lsu_bus_master (
   input  logic               clk,
   input  logic               rst,
   input  lsu_pkg::lsu_op_t   dc2,
   input  lsu_pkg::lsu_op_t   dc5,
   input  logic               ld_bus_req,
   input  logic               fwd_take,
   input  lsu_pkg::dword_t    fwd_data,
   input  lsu_pkg::wb_s2m_t   wb_i,
   output lsu_pkg::wb_m2s_t   wb_o,
   output logic               st_done,
   output logic               ld_done,
   output lsu_pkg::lsu_resp_t resp,
   output logic               resp_valid
);

   import lsu_pkg::*;

   typedef enum logic [2:0] {
      IDLE,
      WR_LO,
      WR_HI,
      RD_LO,
      RD_HI
   } state_e;

   state_e state;
   state_e state_nxt;
   logic   ack;
   dword_t rd_lo_q;                        // lo dword of a dual read
   dword_t bus_lo;
   dword_t bus_hi;
   dword_t bus_data;

   assign ack = wb_i.ack;

   // *********************************************************
   // beat sequencing
   // *********************************************************
   always_comb begin
      state_nxt = state;
      case (state)
         IDLE: begin
            if (dc5.valid) begin
               state_nxt = WR_LO;                // stores always go first
            end else if (ld_bus_req) begin
               state_nxt = RD_LO;
            end
         end
         WR_LO: if (ack) state_nxt = dc5.dual ? WR_HI : IDLE;
         WR_HI: if (ack) state_nxt = IDLE;
         RD_LO: if (ack) state_nxt = dc2.dual ? RD_HI : IDLE;
         RD_HI: if (ack) state_nxt = IDLE;
         default: state_nxt = IDLE;
      endcase
   end

   assign st_done = ack & (((state == WR_LO) & ~dc5.dual) | (state == WR_HI));
   assign ld_done = ack & (((state == RD_LO) & ~dc2.dual) | (state == RD_HI));

   // bus outputs follow the state, dc5/dc2 hold still until the last ack
   always_comb begin
      wb_o     = '0;
      wb_o.cyc = (state != IDLE);
      wb_o.stb = (state != IDLE);
      case (state)
         WR_LO: begin
            wb_o.we  = 1'b1;
            wb_o.adr = dc5.idx_lo;
            wb_o.dat = dc5.data_lo;
            wb_o.sel = dc5.byteen_lo;
         end
         WR_HI: begin
            wb_o.we  = 1'b1;
            wb_o.adr = dc5.idx_hi;
            wb_o.dat = dc5.data_hi;
            wb_o.sel = dc5.byteen_hi;
         end
         RD_LO: begin
            wb_o.adr = dc2.idx_lo;
            wb_o.sel = dc2.byteen_lo;
         end
         RD_HI: begin
            wb_o.adr = dc2.idx_hi;
            wb_o.sel = dc2.byteen_hi;
         end
         default: wb_o.we = 1'b0;
      endcase
   end

   always_ff @(posedge clk) begin
      if (rst) begin
         state <= IDLE;
      end else begin
         state <= state_nxt;
      end
   end

   always_ff @(posedge clk) begin
      if ((state == RD_LO) && ack) begin
         rd_lo_q <= wb_i.dat;
      end
   end

   // *********************************************************
   // load data and response
   // *********************************************************
   assign bus_lo   = (state == RD_HI) ? rd_lo_q : wb_i.dat;
   assign bus_hi   = (state == RD_HI) ? wb_i.dat : '0;
   assign bus_data = load_align(bus_lo, bus_hi, dc2.byteen_lo, dc2.byteen_hi, dc2.offset);

   always_ff @(posedge clk) begin
      if (rst) begin
         resp_valid <= 1'b0;
      end else begin
         resp_valid <= fwd_take | ld_done;       // one pulse per load
      end
   end

   always_ff @(posedge clk) begin
      if (fwd_take | ld_done) begin
         resp.data <= fwd_take ? fwd_data : bus_data;
         resp.fwd  <= fwd_take;
      end
   end

endmodule

/* hw/lsu_fwd_match.sv */
// lsu forward match: per-byte hits of a dc2 load against dc3..dc5 stores and load disposition
`timescale 1ns/1ps

module lsu_fwd_match (
   input  lsu_pkg::lsu_op_t  dc2,
   input  lsu_pkg::lsu_op_t  dc3,
   input  lsu_pkg::lsu_op_t  dc4,
   input  lsu_pkg::lsu_op_t  dc5,
   input  logic              pipe_empty,
   output logic              fwd_take,     // load fully covered by in-flight stores
   output lsu_pkg::dword_t   fwd_data,
   output logic              ld_bus_req    // load must go to memory
);

   import lsu_pkg::*;

   lsu_op_t    st [3];                     // 0 is dc3, the youngest
   logic [2:0] m_ll;                       // store lo dword vs load lo dword
   logic [2:0] m_lh;                       // store lo vs load hi
   logic [2:0] m_hl;                       // store hi vs load lo
   logic [2:0] m_hh;                       // store hi vs load hi
   byteen_t    hit_lo;
   byteen_t    hit_hi;
   dword_t     fwd_lo;
   dword_t     fwd_hi;
   logic       is_ld;
   logic       full_hit;

   assign st[0] = dc3;
   assign st[1] = dc4;
   assign st[2] = dc5;

   assign is_ld = dc2.valid & dc2.load;

   // *********************************************************
   // dword index compare, four ways per stage
   // *********************************************************
   always_comb begin
      for (int s = 0; s < 3; s++) begin
         m_ll[s] = st[s].valid & (st[s].idx_lo == dc2.idx_lo);
         m_lh[s] = st[s].valid & (st[s].idx_lo == dc2.idx_hi);
         m_hl[s] = st[s].valid & (st[s].idx_hi == dc2.idx_lo);
         m_hh[s] = st[s].valid & (st[s].idx_hi == dc2.idx_hi);
      end
   end

   // *********************************************************
   // byte hits and forwarded bytes
   // *********************************************************

   // walk from dc5 to dc3 so a younger store overwrites an older one
   always_comb begin
      hit_lo = '0;
      hit_hi = '0;
      fwd_lo = '0;
      fwd_hi = '0;
      for (int b = 0; b < BYTES; b++) begin
         for (int s = 2; s >= 0; s--) begin
            if (m_ll[s] & st[s].byteen_lo[b] & dc2.byteen_lo[b]) begin
               hit_lo[b]        = 1'b1;
               fwd_lo[8*b +: 8] = st[s].data_lo[8*b +: 8];
            end
            if (m_hl[s] & st[s].byteen_hi[b] & dc2.byteen_lo[b]) begin
               hit_lo[b]        = 1'b1;
               fwd_lo[8*b +: 8] = st[s].data_hi[8*b +: 8];
            end
            if (m_lh[s] & st[s].byteen_lo[b] & dc2.byteen_hi[b]) begin
               hit_hi[b]        = 1'b1;
               fwd_hi[8*b +: 8] = st[s].data_lo[8*b +: 8];
            end
            if (m_hh[s] & st[s].byteen_hi[b] & dc2.byteen_hi[b]) begin
               hit_hi[b]        = 1'b1;
               fwd_hi[8*b +: 8] = st[s].data_hi[8*b +: 8];
            end
         end
      end
   end

   // every enabled byte of both halves must be covered
   assign full_hit = (&(hit_lo | ~dc2.byteen_lo)) & (&(hit_hi | ~dc2.byteen_hi));

   assign fwd_take   = is_ld & full_hit;
   assign ld_bus_req = is_ld & ~full_hit & pipe_empty;   // partial hits wait for the drain

   assign fwd_data = load_align(fwd_lo, fwd_hi, dc2.byteen_lo, dc2.byteen_hi, dc2.offset);

endmodule

/* hw/lsu_fwd_top.sv */
// lsu forwarding top: request decode, store pipe, forward match and Wishbone bus master
`timescale 1ns/1ps

module lsu_fwd_top (
   input  logic               clk,
   input  logic               rst,
   input  lsu_pkg::lsu_req_t  req,
   input  logic               req_valid,
   output logic               req_ready,
   output lsu_pkg::lsu_resp_t resp,
   output logic               resp_valid,
   output lsu_pkg::wb_m2s_t   wb_o,
   input  lsu_pkg::wb_s2m_t   wb_i
);

   import lsu_pkg::*;

   lsu_op_t dc2;
   lsu_op_t dc3;
   lsu_op_t dc4;
   lsu_op_t dc5;
   logic    dc2_take;
   logic    st_take;
   logic    fwd_take;
   logic    ld_done;
   logic    st_done;
   logic    pipe_empty;
   logic    ld_bus_req;
   dword_t  fwd_data;

   // dc2 empties when a store moves on or a load is answered
   assign dc2_take = st_take | fwd_take | ld_done;

   lsu_req_decode u_req_decode (
      .clk       (clk),
      .rst       (rst),
      .req       (req),
      .req_valid (req_valid),
      .dc2_take  (dc2_take),
      .req_ready (req_ready),
      .dc2       (dc2)
   );

   lsu_store_pipe u_store_pipe (
      .clk        (clk),
      .rst        (rst),
      .dc2        (dc2),
      .st_done    (st_done),
      .dc3        (dc3),
      .dc4        (dc4),
      .dc5        (dc5),
      .st_take    (st_take),
      .pipe_empty (pipe_empty)
   );

   lsu_fwd_match u_fwd_match (
      .dc2        (dc2),
      .dc3        (dc3),
      .dc4        (dc4),
      .dc5        (dc5),
      .pipe_empty (pipe_empty),
      .fwd_take   (fwd_take),
      .fwd_data   (fwd_data),
      .ld_bus_req (ld_bus_req)
   );

   lsu_bus_master u_bus_master (
      .clk        (clk),
      .rst        (rst),
      .dc2        (dc2),
      .dc5        (dc5),
      .ld_bus_req (ld_bus_req),
      .fwd_take   (fwd_take),
      .fwd_data   (fwd_data),
      .wb_i       (wb_i),
      .wb_o       (wb_o),
      .st_done    (st_done),
      .ld_done    (ld_done),
      .resp       (resp),
      .resp_valid (resp_valid)
   );

endmodule

/* hw/lsu_pkg.sv */
// lsu package: widths, size codes, request/stage/response structs and Wishbone bundles
package lsu_pkg;

   localparam int ADDR_W = 32;
   localparam int DATA_W = 64;
   localparam int BYTES  = 8;                    // bytes per dword

   typedef logic [ADDR_W-1:0] addr_t;
   typedef logic [ADDR_W-4:0] dw_idx_t;          // address bits above the byte offset
   typedef logic [DATA_W-1:0] dword_t;
   typedef logic [BYTES-1:0]  byteen_t;
   typedef logic [1:0]        size_t;

   localparam size_t SIZE_B = 2'd0;
   localparam size_t SIZE_H = 2'd1;
   localparam size_t SIZE_W = 2'd2;
   localparam size_t SIZE_D = 2'd3;

   // *********************************************************
   // request, pipeline entry and response
   // *********************************************************
   typedef struct packed {
      logic   load;
      size_t  size;
      addr_t  addr;
      dword_t data;                              // store data, right aligned
   } lsu_req_t;

   typedef struct packed {
      logic       valid;
      logic       load;
      logic       dual;                          // access crosses into the next dword
      dw_idx_t    idx_lo;
      dw_idx_t    idx_hi;
      byteen_t    byteen_lo;
      byteen_t    byteen_hi;
      dword_t     data_lo;                       // store data already shifted into place
      dword_t     data_hi;
      logic [2:0] offset;                        // low address bits
   } lsu_op_t;

   typedef struct packed {
      dword_t data;
      logic   fwd;                               // data came from the store pipe
   } lsu_resp_t;

   // *********************************************************
   // wishbone classic
   // *********************************************************
   typedef struct packed {
      logic    cyc;
      logic    stb;
      logic    we;
      dw_idx_t adr;
      dword_t  dat;
      byteen_t sel;
   } wb_m2s_t;

   typedef struct packed {
      dword_t dat;
      logic   ack;
   } wb_s2m_t;

   // lo/hi pair down to the load offset, zero outside the enabled bytes
   function automatic dword_t load_align(dword_t lo, dword_t hi, byteen_t be_lo,
                                         byteen_t be_hi, logic [2:0] offset);
      logic [2*DATA_W-1:0] wide;
      logic [2*BYTES-1:0]  be_wide;
      dword_t              mask;
      wide    = {hi, lo} >> {offset, 3'b000};
      be_wide = {be_hi, be_lo} >> offset;
      for (int b = 0; b < BYTES; b++) begin
         mask[8*b +: 8] = {8{be_wide[b]}};
      end
      return wide[DATA_W-1:0] & mask;
   endfunction

endpackage

/* hw/lsu_req_decode.sv */
// lsu request decode: registers one request into dc2 with byte enables and hi/lo split
`timescale 1ns/1ps

module lsu_req_decode (
   input  logic               clk,
   input  logic               rst,
   input  lsu_pkg::lsu_req_t  req,
   input  logic               req_valid,
   input  logic               dc2_take,   // dc2 entry leaves this cycle
   output logic               req_ready,
   output lsu_pkg::lsu_op_t   dc2
);

   import lsu_pkg::*;

   byteen_t               be;
   logic [2:0]            span;           // access length minus one
   addr_t                 end_addr;
   logic [2*BYTES-1:0]    be_ext;
   logic [2*DATA_W-1:0]   data_ext;
   lsu_op_t               op_nxt;
   logic                  accept;

   assign req_ready = ~dc2.valid | dc2_take;
   assign accept    = req_valid & req_ready;

   // *********************************************************
   // byte enables and end address
   // *********************************************************
   always_comb begin
      case (req.size)
         SIZE_B:  begin be = 8'b0000_0001; span = 3'd0; end
         SIZE_H:  begin be = 8'b0000_0011; span = 3'd1; end
         SIZE_W:  begin be = 8'b0000_1111; span = 3'd3; end
         default: begin be = 8'b1111_1111; span = 3'd7; end
      endcase
   end

   assign end_addr = req.addr + addr_t'(span);

   // 8 enables and 64 data bits spread over a lo/hi dword pair
   assign be_ext   = {{BYTES{1'b0}}, be} << req.addr[2:0];
   assign data_ext = {{DATA_W{1'b0}}, req.data} << {req.addr[2:0], 3'b000};

   always_comb begin
      op_nxt.valid     = 1'b1;
      op_nxt.load      = req.load;
      op_nxt.dual      = (end_addr[3] != req.addr[3]);
      op_nxt.idx_lo    = req.addr[ADDR_W-1:3];
      op_nxt.idx_hi    = end_addr[ADDR_W-1:3];   // same as lo unless dual
      op_nxt.byteen_lo = be_ext[BYTES-1:0];
      op_nxt.byteen_hi = be_ext[2*BYTES-1:BYTES];
      op_nxt.data_lo   = data_ext[DATA_W-1:0];
      op_nxt.data_hi   = data_ext[2*DATA_W-1:DATA_W];
      op_nxt.offset    = req.addr[2:0];
   end

   // dc2 stage register
   always_ff @(posedge clk) begin
      if (rst) begin
         dc2.valid <= 1'b0;
      end else if (accept) begin
         dc2 <= op_nxt;
      end else if (dc2_take) begin
         dc2.valid <= 1'b0;                      // entry consumed, nothing new behind it
      end
   end

endmodule

/* hw/lsu_store_pipe.sv */
// lsu store pipe: dc3..dc5 in-flight stores, oldest in dc5, bubbles collapse forward
`timescale 1ns/1ps

module lsu_store_pipe (
   input  logic              clk,
   input  logic              rst,
   input  lsu_pkg::lsu_op_t  dc2,
   input  logic              st_done,      // last beat of the dc5 store acked
   output lsu_pkg::lsu_op_t  dc3,
   output lsu_pkg::lsu_op_t  dc4,
   output lsu_pkg::lsu_op_t  dc5,
   output logic              st_take,
   output logic              pipe_empty
);

   import lsu_pkg::*;

   logic adv4;                             // dc4 moves into dc5
   logic adv3;                             // dc3 moves into dc4

   // *********************************************************
   // advance conditions
   // *********************************************************

   // a stage moves when the one ahead is empty or leaving
   assign adv4 = dc4.valid & (~dc5.valid | st_done);
   assign adv3 = dc3.valid & (~dc4.valid | adv4);

   // only stores enter, loads stay in dc2 until answered
   assign st_take = dc2.valid & ~dc2.load & (~dc3.valid | adv3);

   assign pipe_empty = ~dc3.valid & ~dc4.valid & ~dc5.valid;

   // *********************************************************
   // stage registers
   // *********************************************************
   always_ff @(posedge clk) begin
      if (rst) begin
         dc3.valid <= 1'b0;
         dc4.valid <= 1'b0;
         dc5.valid <= 1'b0;
      end else begin
         // dc5 is held until the bus master finishes its beats
         if (adv4) begin
            dc5 <= dc4;
         end else if (st_done) begin
            dc5.valid <= 1'b0;
         end

         if (adv3) begin
            dc4 <= dc3;
         end else if (adv4) begin
            dc4.valid <= 1'b0;
         end

         if (st_take) begin
            dc3 <= dc2;
         end else if (adv3) begin
            dc3.valid <= 1'b0;                   // bubble left behind
         end
      end
   end

endmodule

/* tb/lsu_fwd_checker.sv */
// lsu checker: Wishbone handshake and reset assertions bound to the lsu top level
`timescale 1ns/1ps

module lsu_fwd_checker (
   input logic              clk,
   input logic              rst,
   input lsu_pkg::wb_m2s_t  wb_o,
   input lsu_pkg::wb_s2m_t  wb_i,
   input logic              resp_valid
);

   import lsu_pkg::*;

   // *********************************************************
   // wishbone classic rules
   // *********************************************************
   stb_needs_cyc: assert property (@(posedge clk) disable iff (rst)
      wb_o.stb |-> wb_o.cyc)
      else $error("stb high without cyc");

   // master holds the beat until the slave acks
   hold_until_ack: assert property (@(posedge clk) disable iff (rst)
      wb_o.stb && !wb_i.ack |=> $stable(wb_o))
      else $error("wb_o changed while a beat was waiting for ack");

   // *********************************************************
   // reset
   // *********************************************************
   quiet_in_reset: assert property (@(posedge clk)
      rst |-> !wb_o.cyc && !resp_valid)
      else $error("cyc or resp_valid high during reset");

   quiet_after_reset: assert property (@(posedge clk)
      rst |=> !wb_o.cyc && !resp_valid)
      else $error("cyc or resp_valid high in the cycle after reset");

endmodule

bind lsu_fwd_top lsu_fwd_checker u_checker (
   .clk        (clk),
   .rst        (rst),
   .wb_o       (wb_o),
   .wb_i       (wb_i),
   .resp_valid (resp_valid)
);

/* tb/lsu_fwd_tb.sv */
// lsu testbench: Wishbone memory model, byte reference model, directed and random requests
`timescale 1ns/1ps

module lsu_fwd_tb;

   import lsu_pkg::*;

   logic clk = 1'b0;
   logic rst = 1'b1;
   lsu_req_t  req = '0;
   logic      req_valid = 1'b0;
   logic      req_ready;
   lsu_resp_t resp;
   logic      resp_valid;
   wb_m2s_t   wb_o;
   wb_s2m_t   wb_i = '0;

   dword_t     mem [64];
   logic [7:0] ref_mem [512];
   logic [31:0] rnd_state = 32'd69878;
   int  wait_cnt = -1;
   bit  slow = 0;                       // long wait states for back-pressure
   int  rd_beats = 0;
   int  ncyc = 0;
   int  errors = 0;
   int  checks = 0;
   int  tests = 0;
   int  failed = 0;
   int  ready_low = 0;
   bit  hung = 0;
   byteen_t  wr_sel_q [$];
   dw_idx_t  wr_adr_q [$];
   dword_t   exp_data_q [$];
   int       exp_fwd_q [$];             // 0 clear, 1 set, 2 either
   int       exp_acc_q [$];             // acceptance cycle, -1 if latency is free

   lsu_fwd_top DUT (
      .clk (clk), .rst (rst), .req (req), .req_valid (req_valid), .req_ready (req_ready),
      .resp (resp), .resp_valid (resp_valid), .wb_o (wb_o), .wb_i (wb_i)
   );

   always #10 clk = ~clk;

   function automatic logic [31:0] xorshift(input logic [31:0] x);
      x = x ^ (x << 13);
      x = x ^ (x >> 17);
      x = x ^ (x << 5);
      return x;
   endfunction

   // ************************************************************
   // wishbone slave with random wait states
   // ************************************************************
   always @(negedge clk) begin
      if (wb_i.ack) begin
         wb_i.ack = 1'b0;                // one ack per beat
      end else if (wb_o.cyc && wb_o.stb) begin
         if (wait_cnt < 0) begin
            rnd_state = xorshift(rnd_state);
            wait_cnt = slow ? 4 + int'(rnd_state % 4) : int'(rnd_state % 4);
         end
         if (wait_cnt == 0) begin
            if (wb_o.we) begin
               for (int b = 0; b < BYTES; b++)
                  if (wb_o.sel[b]) mem[wb_o.adr[5:0]][8*b +: 8] = wb_o.dat[8*b +: 8];
               wr_sel_q.push_back(wb_o.sel);
               wr_adr_q.push_back(wb_o.adr);
            end else begin
               rd_beats++;
            end
            wb_i.dat = mem[wb_o.adr[5:0]];
            wb_i.ack = 1'b1;
            wait_cnt = -1;
         end else begin
            wait_cnt--;
         end
      end
   end

   // response checker, also the cycle counter
   always @(negedge clk) begin
      ncyc++;
      if (resp_valid) begin
         checks++;
         assert (exp_data_q.size() > 0)
         else begin
            $display("[ERROR] %0t unexpected response", $time);
            errors++;
         end
         if (exp_data_q.size() > 0) begin
            assert (resp.data == exp_data_q[0])
            else begin
               $display("[ERROR] %0t load data %h, expected %h", $time, resp.data,
                        exp_data_q[0]);
               errors++;
            end
            assert (exp_fwd_q[0] == 2 || int'(resp.fwd) == exp_fwd_q[0])
            else begin
               $display("[ERROR] %0t fwd flag %0b, expected %0d", $time, resp.fwd,
                        exp_fwd_q[0]);
               errors++;
            end
            assert (exp_acc_q[0] < 0 || ncyc - exp_acc_q[0] == 2)
            else begin
               $display("[ERROR] %0t forwarded load took %0d cycles", $time,
                        ncyc - exp_acc_q[0]);
               errors++;
            end
            void'(exp_data_q.pop_front());
            void'(exp_fwd_q.pop_front());
            void'(exp_acc_q.pop_front());
         end
      end
   end

   // ************************************************************
   // request driver and reference model
   // ************************************************************

   // called on a falling edge, so back-to-back calls keep req_valid high
   task automatic send(input logic load, input size_t size, input int addr,
                       input dword_t data, input int fwd, input bit timed);
      int     n;
      int     guard;
      dword_t exp;
      n = 1 << size;
      guard = 0;
      exp = '0;
      if (!hung) begin
         req.load = load;
         req.size = size;
         req.addr = addr_t'(addr);
         req.data = data;
         req_valid = 1'b1;
         #1;
         while (!req_ready && guard < 200) begin
            if (slow) ready_low++;
            guard++;
            @(negedge clk);
            #1;
         end
         if (!req_ready) begin
            $display("timeout: request at %h was never accepted", addr);
            hung = 1;
            errors++;
         end else begin
            // ordered after all earlier stores, so the reference bytes are exact
            for (int k = 0; k < n; k++) begin
               if (load) exp[8*k +: 8] = ref_mem[addr + k];
               else ref_mem[addr + k] = data[8*k +: 8];
            end
            if (load) begin
               exp_data_q.push_back(exp);
               exp_fwd_q.push_back(fwd);
               exp_acc_q.push_back(timed ? ncyc : -1);
            end
            @(posedge clk);
         end
         @(negedge clk);
         req_valid = 1'b0;
      end
   endtask

   task automatic drain();
      int guard;
      guard = 0;
      while (!hung && guard < 2000 && (exp_data_q.size() != 0 || wb_o.cyc ||
             !DUT.pipe_empty || DUT.dc2.valid)) begin
         @(negedge clk);
         guard++;
      end
      if (guard >= 2000) begin
         $display("timeout: the unit did not go idle, %0d loads unanswered",
                  exp_data_q.size());
         hung = 1;
         errors++;
      end
   endtask

   task automatic report(input string name, input int errs_before);
      tests++;
      if (errors != errs_before) failed++;
      $display("test %0d %s: %s", tests, name, (errors == errs_before) ? "ok" : "failed");
   endtask

   initial begin
      int e;
      int rb;
      for (int a = 0; a < 512; a++) ref_mem[a] = 8'(a ^ (a >> 8) ^ 8'h3c);
      for (int i = 0; i < 64; i++)
         for (int b = 0; b < 8; b++) mem[i][8*b +: 8] = ref_mem[8*i + b];

      // test 1: reset
      e = errors;
      repeat (8) begin
         @(negedge clk);
         assert (!resp_valid && !wb_o.cyc && !wb_o.stb)
         else begin
            $display("[ERROR] %0t bus or response active during reset", $time);
            errors++;
         end
      end
      rst = 1'b0;
      repeat (3) begin
         @(negedge clk);
         assert (!resp_valid && !wb_o.cyc && !wb_o.stb && req_ready)
         else begin
            $display("[ERROR] %0t unit not idle and ready after reset", $time);
            errors++;
         end
      end
      report("reset", e);

      // test 2: store, idle, load from another dword
      e = errors;
      wr_sel_q.delete();
      send(1'b0, SIZE_W, 'h14, 64'h1122_3344, 0, 0);
      repeat (5) @(negedge clk);
      send(1'b1, SIZE_D, 'h28, '0, 0, 0);
      drain();
      assert (wr_sel_q.size() == 1 && wr_sel_q[0] == 8'hf0)
      else begin
         $display("[ERROR] %0t write sel wrong or beat count %0d", $time, wr_sel_q.size());
         errors++;
      end
      report("store then bus load", e);

      // test 3: covered load right behind its store
      e = errors;
      rb = rd_beats;
      send(1'b0, SIZE_D, 'h40, 64'h8877_6655_4433_2211, 1, 0);
      send(1'b1, SIZE_W, 'h44, '0, 1, 1);
      drain();
      assert (rd_beats == rb)
      else begin
         $display("[ERROR] %0t forwarded load caused a read beat", $time);
         errors++;
      end
      report("full forward", e);

      // test 4: partial hit waits for the drain
      e = errors;
      send(1'b0, SIZE_B, 'h61, 64'h5a, 0, 0);
      send(1'b1, SIZE_D, 'h60, '0, 0, 0);
      drain();
      report("partial hit", e);

      // test 5: dual store and dual loads
      e = errors;
      wr_adr_q.delete();
      wr_sel_q.delete();
      send(1'b0, SIZE_D, 'h7d, 64'hfedc_ba98_7654_3210, 0, 0);
      send(1'b1, SIZE_H, 'h7f, '0, 1, 0);
      drain();
      send(1'b1, SIZE_W, 'h7e, '0, 0, 0);
      drain();
      assert (wr_adr_q.size() == 2 && wr_adr_q[0] == 'd15 && wr_adr_q[1] == 'd16 &&
              wr_sel_q[0] == 8'he0 && wr_sel_q[1] == 8'h1f)
      else begin
         $display("[ERROR] %0t dual store beats wrong, %0d beats", $time, wr_adr_q.size());
         errors++;
      end
      report("dual access", e);

      // test 6: random mix, the middle part is stores only under slow acks
      e = errors;
      ready_low = 0;
      for (int i = 0; i < 200; i++) begin
         if (i == 80) drain();           // slow phase starts from an idle unit
         slow = (i >= 80 && i < 120);
         rnd_state = xorshift(rnd_state);
         send(rnd_state[0] & ~slow, size_t'(rnd_state[2:1]), 'h100 + int'(rnd_state[8:3]),
              {xorshift(rnd_state + 1), xorshift(rnd_state + 7)}, 2, 0);
      end
      slow = 0;
      drain();
      assert (ready_low > 0)
      else begin
         $display("back-pressure never showed: req_ready stayed high under slow acks");
         errors++;
      end
      report("random mix", e);

      $display("tests %0d, failed %0d, checks %0d, errors %0d", tests, failed, checks, errors);
      if (errors == 0 && !hung) begin
         $display("Simulation finished: PASS");
      end else begin
         $display("Simulation finished: FAIL");
      end
      $finish;
   end

endmodule

/* vlog.f */
hw/lsu_pkg.sv
hw/lsu_req_decode.sv
hw/lsu_store_pipe.sv
hw/lsu_fwd_match.sv
hw/lsu_bus_master.sv
hw/lsu_fwd_top.sv
tb/lsu_fwd_checker.sv
tb/lsu_fwd_tb.sv
